// File: regRead.f
+incdir+include
rtl/regReadPkg.sv
rtl/physRegFile.sv
rtl/bypassMatch.sv
rtl/operandMerge.sv
rtl/readyTable.sv
rtl/regReadStage.sv
sim/tbRegRead.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the register-read stage testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f regRead.f --top-module tbRegRead -o simRegRead

./obj_dir/simRegRead | tee sim.log

if grep -q "Test failed" sim.log || ! grep -q "Test passed" sim.log; then
  exit 1
fi
exit 0

// File: sim/tbRegRead.sv
// Testbench for the register-read stage: clock, reset, LFSR data, directed tests and watchdog
`timescale 1ns/1ps
`include "regRead_macros.svh"

module tbRegRead;

  localparam int ClkPeriod    = 20;
  localparam int TestCycles   = 40;
  localparam int MarginCycles = 50;

  logic                       clk;
  logic                       arstN;
  regReadPkg::issuePkt_t      issue [`RR_LANES];
  regReadPkg::bypassPkt_t     bypass [`RR_BYPASS];
  regReadPkg::tagUpdate_t     unmap [`RR_LANES];
  regReadPkg::tagUpdate_t     wakeup [`RR_LANES];
  regReadPkg::mispredictPkt_t mispredict;
  logic                       recover;
  logic                       exception;
  regReadPkg::execPkt_t       execOut [`RR_LANES];
  logic [`RR_PHYS_REGS-1:0]   phyRegRdy;

  logic [31:0]              lfsrState = 32'hc14;
  logic [`RR_DATA_W-1:0]    rfModel [`RR_PHYS_REGS];  // Words the register file should hold
  logic [`RR_PHYS_REGS-1:0] rdyModel;
  int                       checkCount = 0;
  int                       errorCount = 0;

  regReadStage dut_i (
    .clk          (clk),
    .arstN_i      (arstN),
    .issue_i      (issue),
    .bypass_i     (bypass),
    .unmap_i      (unmap),
    .wakeup_i     (wakeup),
    .mispredict_i (mispredict),
    .recover_i    (recover),
    .exception_i  (exception),
    .exec_o       (execOut),
    .phyRegRdy_o  (phyRegRdy)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  initial begin
    #((TestCycles + MarginCycles) * ClkPeriod);
    $display("Watchdog expired before the tests finished");
    $display("Test failed");
    $finish;
  end

  // Galois LFSR stepped once for every bit taken
  function automatic logic [31:0] randBits(input int nBits);
    logic [31:0] value;
    logic        outBit;
    value = '0;
    for (int i = 0; i < nBits; i++) begin
      outBit    = lfsrState[0];
      lfsrState = lfsrState >> 1;
      if (outBit) lfsrState = lfsrState ^ 32'h8020_0003;
      value = {value[30:0], outBit};
    end
    return value;
  endfunction

  function automatic logic [`RR_PHYS_REGS-1:0] resetPattern();
    logic [`RR_PHYS_REGS-1:0] pattern;
    for (int i = 0; i < `RR_PHYS_REGS; i++) pattern[i] = (i < `RR_ARCH_REGS);
    return pattern;
  endfunction

  task automatic stepCycle();
    @(posedge clk);
    #2;  // Inputs move away from the sampling edge
  endtask

  task automatic clearInputs();
    for (int l = 0; l < `RR_LANES; l++) begin
      issue[l]  = '0;
      unmap[l]  = '0;
      wakeup[l] = '0;
    end
    for (int b = 0; b < `RR_BYPASS; b++) bypass[b] = '0;
    mispredict = '0;
    recover    = 1'b0;
    exception  = 1'b0;
  endtask

  task automatic checkValue(input string name, input logic [63:0] got, input logic [63:0] exp);
    checkCount++;
    assert (got === exp) else begin
      errorCount++;
      $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  // Writes both buses for one cycle and records the words in the model
  task automatic writeRegs(input regReadPkg::physTag_t tagA, input regReadPkg::physTag_t tagB);
    bypass[0].valid   = 1'b1;
    bypass[0].destTag = tagA;
    bypass[0].data    = randBits(`RR_DATA_W);
    bypass[1].valid   = 1'b1;
    bypass[1].destTag = tagB;
    bypass[1].data    = randBits(`RR_DATA_W);
    rfModel[tagA]     = bypass[0].data;
    rfModel[tagB]     = bypass[1].data;
    stepCycle();
    for (int b = 0; b < `RR_BYPASS; b++) bypass[b] = '0;
  endtask

  task automatic checkResetState();
    checkValue("phyRegRdy_o", 64'(phyRegRdy), 64'(resetPattern()));
    for (int l = 0; l < `RR_LANES; l++)
      checkValue($sformatf("exec_o[%0d].valid", l), 64'(execOut[l].issue.valid), 64'(0));
  endtask

  task automatic readRegFile();
    regReadPkg::issuePkt_t sent [`RR_LANES];
    writeRegs(6'd5, 6'd9);
    writeRegs(6'd40, 6'd63);
    stepCycle();  // Idle cycle between the writes and the reads
    issue[0].srcTag1 = 6'd5;
    issue[0].srcTag2 = 6'd9;
    issue[1].srcTag1 = 6'd40;
    issue[1].srcTag2 = 6'd63;
    for (int l = 0; l < `RR_LANES; l++) begin
      issue[l].valid   = 1'b1;
      issue[l].destTag = 6'(randBits(6));
      issue[l].mask    = 4'(randBits(`RR_CKPTS));
      issue[l].payload = 16'(randBits(`RR_PAYLOAD_W));
      sent[l] = issue[l];
    end
    stepCycle();
    clearInputs();
    for (int l = 0; l < `RR_LANES; l++) begin
      checkValue($sformatf("exec_o[%0d].valid", l), 64'(execOut[l].issue.valid), 64'(1));
      checkValue($sformatf("exec_o[%0d].data1", l), 64'(execOut[l].data1),
                 64'(rfModel[sent[l].srcTag1]));
      checkValue($sformatf("exec_o[%0d].data2", l), 64'(execOut[l].data2),
                 64'(rfModel[sent[l].srcTag2]));
      checkValue($sformatf("exec_o[%0d].payload", l), 64'(execOut[l].issue.payload),
                 64'(sent[l].payload));
      checkValue($sformatf("exec_o[%0d].mask", l), 64'(execOut[l].issue.mask),
                 64'(sent[l].mask));
      checkValue($sformatf("exec_o[%0d].destTag", l), 64'(execOut[l].issue.destTag),
                 64'(sent[l].destTag));
    end
  endtask

  task automatic forwardDuringRecovery();
    regReadPkg::regData_t newData;
    writeRegs(6'd12, 6'd20);
    stepCycle();
    newData = randBits(`RR_DATA_W);
    issue[0] = '{valid: 1'b1, srcTag1: 6'd12, srcTag2: 6'd20, default: '0};
    issue[1] = '{valid: 1'b1, srcTag1: 6'd20, srcTag2: 6'd12, default: '0};
    bypass[1] = '{valid: 1'b1, destTag: 6'd12, data: newData};
    recover  = 1'b1;  // Forwarding still applies, the write is dropped
    stepCycle();
    clearInputs();
    checkValue("exec_o[0].data1", 64'(execOut[0].data1), 64'(newData));
    checkValue("exec_o[0].data2", 64'(execOut[0].data2), 64'(rfModel[20]));
    checkValue("exec_o[1].data1", 64'(execOut[1].data1), 64'(rfModel[20]));
    checkValue("exec_o[1].data2", 64'(execOut[1].data2), 64'(newData));
    issue[0] = '{valid: 1'b1, srcTag1: 6'd12, srcTag2: 6'd12, default: '0};
    stepCycle();
    clearInputs();
    checkValue("exec_o[0].data1", 64'(execOut[0].data1), 64'(rfModel[12]));
  endtask

  task automatic squashOnMispredict();
    logic [3:0]                 cases [4];
    regReadPkg::mispredictPkt_t mp;
    logic                       expValid;
    cases = '{4'b1110, 4'b0110, 4'b1001, 4'b1111};  // verified, mispredict, ckptId
    for (int c = 0; c < 4; c++) begin
      mp = regReadPkg::mispredictPkt_t'(cases[c]);
      for (int l = 0; l < `RR_LANES; l++) begin
        issue[l]         = '{valid: 1'b1, srcTag1: 6'd5, srcTag2: 6'd9, default: '0};
        issue[l].mask    = 4'(randBits(`RR_CKPTS));
        issue[l].mask[mp.ckptId] = (l == 0);  // Lane 0 depends on the branch, lane 1 does not
      end
      mispredict = mp;
      stepCycle();
      for (int l = 0; l < `RR_LANES; l++) begin
        expValid = !(mp.verified && mp.mispredict && (l == 0));
        checkValue($sformatf("exec_o[%0d].valid case %0d", l, c),
                   64'(execOut[l].issue.valid), 64'(expValid));
      end
    end
    clearInputs();
  endtask

  task automatic updateReadyTable();
    rdyModel = resetPattern();
    unmap[0] = '{valid: 1'b1, tag: 6'd3};
    rdyModel[3] = 1'b0;
    stepCycle();
    clearInputs();
    checkValue("phyRegRdy_o after unmap", 64'(phyRegRdy), 64'(rdyModel));
    wakeup[1] = '{valid: 1'b1, tag: 6'd45};
    rdyModel[45] = 1'b1;
    stepCycle();
    clearInputs();
    checkValue("phyRegRdy_o after wakeup", 64'(phyRegRdy), 64'(rdyModel));
    unmap[0]  = '{valid: 1'b1, tag: 6'd50};
    wakeup[1] = '{valid: 1'b1, tag: 6'd50};
    rdyModel[50] = 1'b1;  // The wakeup wins
    stepCycle();
    clearInputs();
    checkValue("phyRegRdy_o after unmap and wakeup", 64'(phyRegRdy), 64'(rdyModel));
    unmap[1]  = '{valid: 1'b1, tag: 6'd7};
    exception = 1'b1;
    rdyModel  = resetPattern();
    stepCycle();
    clearInputs();
    checkValue("phyRegRdy_o after exception", 64'(phyRegRdy), 64'(rdyModel));
  endtask

  initial begin
    clearInputs();
    arstN = 1'b0;
    repeat (8) @(posedge clk);
    #2;
    arstN = 1'b1;
    checkResetState();
    readRegFile();
    forwardDuringRecovery();
    squashOnMispredict();
    updateReadyTable();
    $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: rtl/regReadStage.sv
// Register-read stage top level: register file, bypass matcher, operand merger, ready table
`timescale 1ns/1ps
`include "regRead_macros.svh"

module regReadStage (
  input  logic                       clk,
  input  logic                       arstN_i,
  input  regReadPkg::issuePkt_t      issue_i [`RR_LANES],
  input  regReadPkg::bypassPkt_t     bypass_i [`RR_BYPASS],
  input  regReadPkg::tagUpdate_t     unmap_i [`RR_LANES],
  input  regReadPkg::tagUpdate_t     wakeup_i [`RR_LANES],
  input  regReadPkg::mispredictPkt_t mispredict_i,
  input  logic                       recover_i,
  input  logic                       exception_i,
  output regReadPkg::execPkt_t       exec_o [`RR_LANES],
  output logic [`RR_PHYS_REGS-1:0]   phyRegRdy_o
);

  regReadPkg::regData_t    rfData [`RR_LANES][2];  // Register file words per source
  regReadPkg::operandSel_t srcSel [`RR_LANES][2];  // Bypass hits per source

  physRegFile regFile (
    .clk       (clk),
    .issue_i   (issue_i),
    .bypass_i  (bypass_i),
    .recover_i (recover_i),
    .rfData_o  (rfData)
  );

  bypassMatch bypMatch (
    .issue_i  (issue_i),
    .bypass_i (bypass_i),
    .srcSel_o (srcSel)
  );

  operandMerge opMerge (
    .clk          (clk),
    .arstN_i      (arstN_i),
    .issue_i      (issue_i),
    .bypass_i     (bypass_i),
    .rfData_i     (rfData),
    .srcSel_i     (srcSel),
    .mispredict_i (mispredict_i),
    .exec_o       (exec_o)
  );

  // Scheduler-side bookkeeping, not on the operand path
  readyTable rdyTable (
    .clk         (clk),
    .arstN_i     (arstN_i),
    .unmap_i     (unmap_i),
    .wakeup_i    (wakeup_i),
    .exception_i (exception_i),
    .phyRegRdy_o (phyRegRdy_o)
  );

endmodule

// File: rtl/readyTable.sv
// Ready bits of the physical registers with unmap, wakeup and exception restore
`timescale 1ns/1ps
`include "regRead_macros.svh"

module readyTable (
  input  logic                     clk,
  input  logic                     arstN_i,
  input  regReadPkg::tagUpdate_t   unmap_i [`RR_LANES],
  input  regReadPkg::tagUpdate_t   wakeup_i [`RR_LANES],
  input  logic                     exception_i,
  output logic [`RR_PHYS_REGS-1:0] phyRegRdy_o
);

  // Architectural mappings hold committed values, the free registers hold nothing yet
  localparam logic [`RR_PHYS_REGS-1:0] RdyInit =
    {{(`RR_PHYS_REGS - `RR_ARCH_REGS){1'b0}}, {`RR_ARCH_REGS{1'b1}}};

  logic [`RR_PHYS_REGS-1:0] rdyQ;
  logic [`RR_PHYS_REGS-1:0] rdyNext;

  always_comb begin
    rdyNext = rdyQ;
    for (int l = 0; l < `RR_LANES; l++) begin
      if (unmap_i[l].valid) begin
        rdyNext[unmap_i[l].tag] = 1'b0;
      end
    end
    for (int l = 0; l < `RR_LANES; l++) begin  // Applied last so a wakeup beats an unmap
      if (wakeup_i[l].valid) begin
        rdyNext[wakeup_i[l].tag] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge arstN_i) begin
    if (!arstN_i) begin
      rdyQ <= RdyInit;
    end else if (exception_i) begin
      rdyQ <= RdyInit;  // Back to the committed mapping
    end else begin
      rdyQ <= rdyNext;
    end
  end

  assign phyRegRdy_o = rdyQ;

endmodule

// File: rtl/operandMerge.sv
// Operand selection between bypass and register file, mispredict squash and output register
`timescale 1ns/1ps
`include "regRead_macros.svh"

module operandMerge (
  input  logic                       clk,
  input  logic                       arstN_i,
  input  regReadPkg::issuePkt_t      issue_i [`RR_LANES],
  input  regReadPkg::bypassPkt_t     bypass_i [`RR_BYPASS],
  input  regReadPkg::regData_t       rfData_i [`RR_LANES][2],
  input  regReadPkg::operandSel_t    srcSel_i [`RR_LANES][2],
  input  regReadPkg::mispredictPkt_t mispredict_i,
  output regReadPkg::execPkt_t       exec_o [`RR_LANES]
);

  regReadPkg::regData_t opData [`RR_LANES][2];
  regReadPkg::execPkt_t pktQ [`RR_LANES];
  logic [`RR_LANES-1:0] laneKill;
  logic [`RR_LANES-1:0] validQ;
  logic                 flushEvent;

  assign flushEvent = mispredict_i.verified & mispredict_i.mispredict;

  always_comb begin
    for (int l = 0; l < `RR_LANES; l++) begin
      for (int s = 0; s < 2; s++) begin
        opData[l][s] = rfData_i[l][s];  // Fall back to the stored value
        for (int b = 0; b < `RR_BYPASS; b++) begin
          if (srcSel_i[l][s][b]) begin
            opData[l][s] = bypass_i[b].data;
          end
        end
      end
      laneKill[l] = flushEvent && issue_i[l].mask[mispredict_i.ckptId];  // Younger than branch
    end
  end

  always_ff @(posedge clk or negedge arstN_i) begin
    if (!arstN_i) begin
      validQ <= '0;
    end else begin
      for (int l = 0; l < `RR_LANES; l++) begin
        validQ[l] <= issue_i[l].valid & ~laneKill[l];
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int l = 0; l < `RR_LANES; l++) begin
      pktQ[l].issue <= issue_i[l];
      pktQ[l].data1 <= opData[l][0];
      pktQ[l].data2 <= opData[l][1];
    end
  end

  // The valid bit comes from the reset flop, the rest from the payload register
  always_comb begin
    for (int l = 0; l < `RR_LANES; l++) begin
      exec_o[l]             = pktQ[l];
      exec_o[l].issue.valid = validQ[l];
    end
  end

endmodule

// File: rtl/bypassMatch.sv
// Bypass tag comparators producing per-source hit vectors for the operand mux
`timescale 1ns/1ps
`include "regRead_macros.svh"

module bypassMatch (
  input  regReadPkg::issuePkt_t   issue_i [`RR_LANES],
  input  regReadPkg::bypassPkt_t  bypass_i [`RR_BYPASS],
  output regReadPkg::operandSel_t srcSel_o [`RR_LANES][2]
);

  regReadPkg::physTag_t srcTag [`RR_LANES][2];

  always_comb begin
    for (int l = 0; l < `RR_LANES; l++) begin
      srcTag[l][0] = issue_i[l].srcTag1;
      srcTag[l][1] = issue_i[l].srcTag2;
    end
  end

  // Recovery only blocks the register write, forwarding still happens
  always_comb begin
    for (int l = 0; l < `RR_LANES; l++) begin
      for (int s = 0; s < 2; s++) begin
        for (int b = 0; b < `RR_BYPASS; b++) begin
          srcSel_o[l][s][b] = bypass_i[b].valid && (srcTag[l][s] == bypass_i[b].destTag);
        end
      end
    end
  end

  // The operand mux downstream assumes a single hit per source
  always_comb begin
    for (int l = 0; l < `RR_LANES; l++) begin
      for (int s = 0; s < 2; s++) begin
        assert ($onehot0(srcSel_o[l][s]))
          else $error("Lane %0d source %0d hits several bypass buses", l, s + 1);
      end
    end
  end

endmodule

// File: rtl/physRegFile.sv
// Physical register file with combinational source reads and recovery-gated bypass writes
`timescale 1ns/1ps
`include "regRead_macros.svh"

module physRegFile (
  input  logic                   clk,
  input  regReadPkg::issuePkt_t  issue_i [`RR_LANES],
  input  regReadPkg::bypassPkt_t bypass_i [`RR_BYPASS],
  input  logic                   recover_i,
  output regReadPkg::regData_t   rfData_o [`RR_LANES][2]
);

  regReadPkg::regData_t regArray [`RR_PHYS_REGS];

  always_ff @(posedge clk) begin
    for (int b = 0; b < `RR_BYPASS; b++) begin
      if (bypass_i[b].valid && !recover_i) begin  // Results of squashed work are dropped
        regArray[bypass_i[b].destTag] <= bypass_i[b].data;
      end
    end
  end

  // A write lands at the clock edge, so same-cycle readers rely on the bypass path
  always_comb begin
    for (int l = 0; l < `RR_LANES; l++) begin
      rfData_o[l][0] = regArray[issue_i[l].srcTag1];
      rfData_o[l][1] = regArray[issue_i[l].srcTag2];
    end
  end

  // Two buses on one tag would race here and also give the operand mux two hits
  for (genvar i = 0; i < `RR_BYPASS; i++) begin : genWrA
    for (genvar j = i + 1; j < `RR_BYPASS; j++) begin : genWrB
      assert property (@(posedge clk)
        !(bypass_i[i].valid && bypass_i[j].valid &&
          bypass_i[i].destTag == bypass_i[j].destTag))
        else $error("Bypass buses %0d and %0d write tag %0d in one cycle",
                    i, j, bypass_i[i].destTag);
    end
  end

endmodule

// File: rtl/regReadPkg.sv
// Packed struct types shared by the register-read stage: tags, issue, bypass and exec packets
`include "regRead_macros.svh"

package regReadPkg;

  typedef logic [`RR_PHYS_LOG-1:0] physTag_t;
  typedef logic [`RR_DATA_W-1:0]   regData_t;
  typedef logic [`RR_CKPTS-1:0]    ckptMask_t;
  typedef logic [`RR_BYPASS-1:0]   operandSel_t;  // One hit bit per writeback bus

  typedef struct packed {
    logic                     valid;
    physTag_t                 srcTag1;
    physTag_t                 srcTag2;
    physTag_t                 destTag;
    ckptMask_t                mask;     // Unresolved branches this lane depends on
    logic [`RR_PAYLOAD_W-1:0] payload;
  } issuePkt_t;

  typedef struct packed {
    logic     valid;
    physTag_t destTag;
    regData_t data;
  } bypassPkt_t;

  // Used for both unmap and wakeup requests
  typedef struct packed {
    logic     valid;
    physTag_t tag;
  } tagUpdate_t;

  typedef struct packed {
    logic                    verified;
    logic                    mispredict;
    logic [`RR_CKPT_LOG-1:0] ckptId;
  } mispredictPkt_t;

  typedef struct packed {
    issuePkt_t issue;
    regData_t  data1;
    regData_t  data2;
  } execPkt_t;

endpackage

// File: include/regRead_macros.svh
// Size macros for the register-read stage: lanes, bypass buses, register file and checkpoints
`ifndef REGREAD_MACROS_SVH
`define REGREAD_MACROS_SVH

// Issue and writeback widths
`define RR_LANES      2   // Issue lanes entering the stage each cycle
`define RR_BYPASS     2   // Writeback buses feeding the bypass network

// Physical register file
`define RR_PHYS_REGS  64
`define RR_PHYS_LOG   6
`define RR_ARCH_REGS  32  // Entries that are ready out of reset
`define RR_DATA_W     32

// Branch checkpoints
`define RR_CKPTS      4
`define RR_CKPT_LOG   2

// Lane fields that only pass through the stage
`define RR_PAYLOAD_W  16

`endif
